// File: verilog/mips_exec_pkg.sv
`default_nettype none

package mips_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  shamt_t;

    // which unit drives the write-back word
    typedef enum logic [1:0] {
        unit_arith,
        unit_logic_shift,
        unit_hilo,
        unit_link
    } unit_e;

    typedef enum logic [1:0] {
        arith_add,
        arith_sub,
        arith_slt,
        arith_sltu
    } arith_op_e;

    typedef enum logic [2:0] {
        ls_and,
        ls_or,
        ls_xor,
        ls_nor,
        ls_lui,
        ls_sll,
        ls_srl,
        ls_sra
    } ls_op_e;

    typedef enum logic [2:0] {
        hilo_none,
        hilo_mult,
        hilo_multu,
        hilo_mfhi,
        hilo_mflo,
        hilo_mthi,
        hilo_mtlo
    } hilo_op_e;

    // decoded operation handed to every datapath unit
    typedef struct packed {
        unit_e     unit;
        arith_op_e arith_op;
        ls_op_e    ls_op;
        hilo_op_e  hilo_op;
        // operand b taken from imm
        logic      use_imm;
        word_t     imm;
        // shift amount from srca[4:0]
        logic      var_shift;
        shamt_t    shamt;
        logic      trap_ovf;
        logic      rsvd;
    } exec_op_t;

endpackage

`default_nettype wire

// File: verilog/exec_ctrl.sv
`default_nettype none

module exec_ctrl (
    input  wire mips_exec_pkg::instr_t i_instr,
    output mips_exec_pkg::exec_op_t    o_op
);
    import mips_exec_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rt;
    logic [15:0] imm16;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];
    assign rt     = i_instr[20:16];
    assign imm16  = i_instr[15:0];

    always_comb begin
        o_op.unit      = unit_arith;
        o_op.arith_op  = arith_add;
        o_op.ls_op     = ls_and;
        o_op.hilo_op   = hilo_none;
        o_op.use_imm   = 1'b0;
        o_op.imm       = {{16{imm16[15]}}, imm16};
        o_op.var_shift = 1'b0;
        o_op.shamt     = i_instr[10:6];
        o_op.trap_ovf  = 1'b0;
        o_op.rsvd      = 1'b0;

        case (opcode)
            // SPECIAL, selected by funct
            6'h00: begin
                case (funct)
                    6'h00: begin o_op.unit = unit_logic_shift; o_op.ls_op = ls_sll; end
                    6'h02: begin o_op.unit = unit_logic_shift; o_op.ls_op = ls_srl; end
                    6'h03: begin o_op.unit = unit_logic_shift; o_op.ls_op = ls_sra; end
                    6'h04, 6'h06, 6'h07: begin
                        o_op.unit      = unit_logic_shift;
                        o_op.var_shift = 1'b1;
                        o_op.ls_op     = (funct[1:0] == 2'b00) ? ls_sll :
                                         (funct[1:0] == 2'b10) ? ls_srl : ls_sra;
                    end
                    6'h09: o_op.unit = unit_link;
                    6'h10: begin o_op.unit = unit_hilo; o_op.hilo_op = hilo_mfhi; end
                    6'h11: begin o_op.unit = unit_hilo; o_op.hilo_op = hilo_mthi; end
                    6'h12: begin o_op.unit = unit_hilo; o_op.hilo_op = hilo_mflo; end
                    6'h13: begin o_op.unit = unit_hilo; o_op.hilo_op = hilo_mtlo; end
                    6'h18: begin o_op.unit = unit_hilo; o_op.hilo_op = hilo_mult; end
                    6'h19: begin o_op.unit = unit_hilo; o_op.hilo_op = hilo_multu; end
                    6'h20: o_op.trap_ovf = 1'b1;
                    6'h21: o_op.arith_op = arith_add;
                    6'h22: begin o_op.arith_op = arith_sub; o_op.trap_ovf = 1'b1; end
                    6'h23: o_op.arith_op = arith_sub;
                    6'h24: begin o_op.unit = unit_logic_shift; o_op.ls_op = ls_and; end
                    6'h25: begin o_op.unit = unit_logic_shift; o_op.ls_op = ls_or; end
                    6'h26: begin o_op.unit = unit_logic_shift; o_op.ls_op = ls_xor; end
                    6'h27: begin o_op.unit = unit_logic_shift; o_op.ls_op = ls_nor; end
                    6'h2a: o_op.arith_op = arith_slt;
                    6'h2b: o_op.arith_op = arith_sltu;
                    default: o_op.rsvd = 1'b1;
                endcase
            end
            // REGIMM, only the linking branches produce a result here
            6'h01: begin
                if (rt == 5'b10000 || rt == 5'b10001) begin
                    o_op.unit = unit_link;
                end else begin
                    o_op.rsvd = 1'b1;
                end
            end
            6'h03: o_op.unit = unit_link;
            6'h08: begin o_op.use_imm = 1'b1; o_op.trap_ovf = 1'b1; end
            6'h09: o_op.use_imm = 1'b1;
            6'h0a: begin o_op.use_imm = 1'b1; o_op.arith_op = arith_slt; end
            6'h0b: begin o_op.use_imm = 1'b1; o_op.arith_op = arith_sltu; end
            6'h0c, 6'h0d, 6'h0e: begin
                o_op.unit    = unit_logic_shift;
                o_op.use_imm = 1'b1;
                // logic immediates are zero extended
                o_op.imm     = {16'h0000, imm16};
                o_op.ls_op   = (opcode[1:0] == 2'b00) ? ls_and :
                               (opcode[1:0] == 2'b01) ? ls_or : ls_xor;
            end
            6'h0f: begin
                o_op.unit  = unit_logic_shift;
                o_op.ls_op = ls_lui;
                o_op.imm   = {imm16, 16'h0000};
            end
            default: o_op.rsvd = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/arith_unit.sv
`default_nettype none

module arith_unit (
    input  wire mips_exec_pkg::exec_op_t i_op,
    input  wire mips_exec_pkg::word_t    i_srca,
    input  wire mips_exec_pkg::word_t    i_srcb,
    output mips_exec_pkg::word_t         o_result,
    output logic                         o_ovf
);
    import mips_exec_pkg::*;

    word_t       opb;
    logic [32:0] sum_w;
    logic [32:0] diff_w;
    logic        lt_signed;
    logic        lt_unsigned;

    assign opb = i_op.use_imm ? i_op.imm : i_srcb;

    // one extra sign bit so overflow shows as a mismatch of the top two bits
    assign sum_w  = {i_srca[31], i_srca} + {opb[31], opb};
    assign diff_w = {i_srca[31], i_srca} - {opb[31], opb};

    assign lt_signed   = $signed(i_srca) < $signed(opb);
    assign lt_unsigned = i_srca < opb;

    always_comb begin
        case (i_op.arith_op)
            arith_add: begin
                o_result = sum_w[31:0];
                o_ovf    = sum_w[32] ^ sum_w[31];
            end
            arith_sub: begin
                o_result = diff_w[31:0];
                o_ovf    = diff_w[32] ^ diff_w[31];
            end
            arith_slt: begin
                o_result = {31'd0, lt_signed};
                o_ovf    = 1'b0;
            end
            default: begin
                o_result = {31'd0, lt_unsigned};
                o_ovf    = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/logic_shift_unit.sv
`default_nettype none

module logic_shift_unit (
    input  wire mips_exec_pkg::exec_op_t i_op,
    input  wire mips_exec_pkg::word_t    i_srca,
    input  wire mips_exec_pkg::word_t    i_srcb,
    output mips_exec_pkg::word_t         o_result
);
    import mips_exec_pkg::*;

    word_t  opb;
    shamt_t amount;

    assign opb = i_op.use_imm ? i_op.imm : i_srcb;

    // variable shifts only look at the low five bits of rs
    assign amount = i_op.var_shift ? i_srca[4:0] : i_op.shamt;

    always_comb begin
        case (i_op.ls_op)
            ls_and: begin
                o_result = i_srca & opb;
            end
            ls_or: begin
                o_result = i_srca | opb;
            end
            ls_xor: begin
                o_result = i_srca ^ opb;
            end
            ls_nor: begin
                o_result = ~(i_srca | opb);
            end
            ls_lui: begin
                // imm already holds the upper half
                o_result = i_op.imm;
            end
            ls_sll: begin
                o_result = i_srcb << amount;
            end
            ls_srl: begin
                o_result = i_srcb >> amount;
            end
            default: begin
                o_result = word_t'($signed(i_srcb) >>> amount);
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/hilo_unit.sv
`default_nettype none

module hilo_unit (
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire                          i_valid,
    input  wire mips_exec_pkg::exec_op_t i_op,
    input  wire mips_exec_pkg::word_t    i_srca,
    input  wire mips_exec_pkg::word_t    i_srcb,
    output mips_exec_pkg::word_t         o_result
);
    import mips_exec_pkg::*;

    word_t       hi;
    word_t       lo;
    logic [63:0] prod_s;
    logic [63:0] prod_u;

    assign prod_s = $signed({{32{i_srca[31]}}, i_srca}) * $signed({{32{i_srcb[31]}}, i_srcb});
    assign prod_u = {32'd0, i_srca} * {32'd0, i_srcb};

    // reserved encodings decode to hilo_none, so they never land here
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (i_valid) begin
            case (i_op.hilo_op)
                hilo_mult: begin
                    hi <= prod_s[63:32];
                    lo <= prod_s[31:0];
                end
                hilo_multu: begin
                    hi <= prod_u[63:32];
                    lo <= prod_u[31:0];
                end
                hilo_mthi: begin
                    hi <= i_srca;
                end
                hilo_mtlo: begin
                    lo <= i_srca;
                end
                default: begin
                    hi <= hi;
                    lo <= lo;
                end
            endcase
        end
    end

    // read side is combinational, the write lands one edge later
    always_comb begin
        case (i_op.hilo_op)
            hilo_mfhi: o_result = hi;
            hilo_mflo: o_result = lo;
            default:   o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/result_select.sv
`default_nettype none

module result_select (
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire                          i_valid,
    input  wire mips_exec_pkg::exec_op_t i_op,
    input  wire mips_exec_pkg::word_t    i_pc,
    input  wire mips_exec_pkg::word_t    i_arith,
    input  wire                          i_ovf,
    input  wire mips_exec_pkg::word_t    i_ls,
    input  wire mips_exec_pkg::word_t    i_hilo,
    output logic                         o_valid,
    output mips_exec_pkg::word_t         o_result,
    output logic                         o_overflow,
    output logic                         o_rsvd
);
    import mips_exec_pkg::*;

    word_t sel;

    always_comb begin
        case (i_op.unit)
            unit_arith:       sel = i_arith;
            unit_logic_shift: sel = i_ls;
            unit_hilo:        sel = i_hilo;
            // return address skips the delay slot
            default:          sel = i_pc + 32'd8;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid    <= 1'b0;
            o_overflow <= 1'b0;
            o_rsvd     <= 1'b0;
        end else begin
            o_valid    <= i_valid;
            o_overflow <= i_valid & i_op.trap_ovf & i_ovf;
            o_rsvd     <= i_valid & i_op.rsvd;
        end
    end

    always_ff @(posedge i_clk) begin
        o_result <= i_op.rsvd ? '0 : sel;
    end

endmodule

`default_nettype wire

// File: verilog/exec_stage.sv
`default_nettype none

module exec_stage (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_valid,
    input  wire mips_exec_pkg::instr_t i_instr,
    input  wire mips_exec_pkg::word_t  i_srca,
    input  wire mips_exec_pkg::word_t  i_srcb,
    input  wire mips_exec_pkg::word_t  i_pc,
    output logic                       o_valid,
    output mips_exec_pkg::word_t       o_result,
    output logic                       o_overflow,
    output logic                       o_rsvd
);
    import mips_exec_pkg::*;

    exec_op_t op;
    word_t    arith_res;
    logic     arith_ovf;
    word_t    ls_res;
    word_t    hilo_res;

    exec_ctrl exec_ctrl_i (
        .i_instr (i_instr),
        .o_op    (op)
    );

    arith_unit arith_unit_i (
        .i_op     (op),
        .i_srca   (i_srca),
        .i_srcb   (i_srcb),
        .o_result (arith_res),
        .o_ovf    (arith_ovf)
    );

    logic_shift_unit logic_shift_unit_i (
        .i_op     (op),
        .i_srca   (i_srca),
        .i_srcb   (i_srcb),
        .o_result (ls_res)
    );

    hilo_unit hilo_unit_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_op     (op),
        .i_srca   (i_srca),
        .i_srcb   (i_srcb),
        .o_result (hilo_res)
    );

    result_select result_select_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_op       (op),
        .i_pc       (i_pc),
        .i_arith    (arith_res),
        .i_ovf      (arith_ovf),
        .i_ls       (ls_res),
        .i_hilo     (hilo_res),
        .o_valid    (o_valid),
        .o_result   (o_result),
        .o_overflow (o_overflow),
        .o_rsvd     (o_rsvd)
    );

endmodule

`default_nettype wire

// File: testbench/exec_stage_props.sv
`default_nettype none

module exec_stage_props (
    input wire                          i_clk,
    input wire                          i_rst_n,
    input wire                          i_valid,
    input wire                          i_out_valid,
    input wire mips_exec_pkg::exec_op_t i_op,
    input wire mips_exec_pkg::word_t    i_hi,
    input wire mips_exec_pkg::word_t    i_lo
);
    import mips_exec_pkg::*;

    int   fail_count = 0;
    logic hilo_write;

    assign hilo_write = i_valid &&
                        (i_op.hilo_op inside {hilo_mult, hilo_multu, hilo_mthi, hilo_mtlo});

    valid_follows: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        1'b1 |=> (i_out_valid == $past(i_valid)))
    else begin
        fail_count++;
        $error("o_valid does not follow i_valid by one cycle");
    end

    valid_low_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_out_valid)
    else begin
        fail_count++;
        $error("o_valid is high while reset is asserted");
    end

    // only mult, multu, mthi and mtlo may move HI or LO
    hilo_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !hilo_write |=> ($stable(i_hi) && $stable(i_lo)))
    else begin
        fail_count++;
        $error("HI or LO changed without a valid write operation");
    end

endmodule

bind exec_stage exec_stage_props exec_stage_props_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_valid),
    .i_out_valid (o_valid),
    .i_op        (op),
    .i_hi        (hilo_unit_i.hi),
    .i_lo        (hilo_unit_i.lo)
);

`default_nettype wire

// File: testbench/exec_stage_tb.sv
`default_nettype none

module exec_stage_tb;
    import mips_exec_pkg::*;

    localparam int RESET_CYCLES = 10;

    typedef struct {
        string  name;
        instr_t instr;
        word_t  srca;
        word_t  srcb;
        word_t  pc;
        word_t  exp_result;
        logic   exp_ovf;
        logic   exp_rsvd;
    } vector_t;

    logic   i_clk;
    logic   i_rst_n;
    logic   i_valid;
    instr_t i_instr;
    word_t  i_srca;
    word_t  i_srcb;
    word_t  i_pc;
    logic   o_valid;
    word_t  o_result;
    logic   o_overflow;
    logic   o_rsvd;

    vector_t     vectors[$];
    word_t       next_pc = 32'h0040_0000;
    word_t       rng_state = 32'h99b9_f2dd;
    int          cycle_count = 0;
    int          cycle_limit = 1000;
    logic [5:0]  rand_funct[8] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h26, 6'h27, 6'h2a, 6'h2b};

    exec_stage exec_stage_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_srca     (i_srca),
        .i_srcb     (i_srcb),
        .i_pc       (i_pc),
        .o_valid    (o_valid),
        .o_result   (o_result),
        .o_overflow (o_overflow),
        .o_rsvd     (o_rsvd)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("Regression failed");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    function automatic word_t xorshift32(input word_t s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic instr_t rtype(input logic [5:0] funct, input logic [4:0] shamt);
        return {6'h00, 5'd0, 5'd0, 5'd0, shamt, funct};
    endfunction

    function automatic instr_t itype(input logic [5:0] opcode, input logic [4:0] rt,
                                     input logic [15:0] imm);
        return {opcode, 5'd0, rt, imm};
    endfunction

    // reference for the register ALU forms, overflow in bit 32
    function automatic logic [32:0] model_alu(input logic [5:0] funct, input word_t a,
                                              input word_t b);
        word_t r;
        logic  v;
        r = '0;
        v = 1'b0;
        case (funct)
            6'h20, 6'h21: begin
                r = a + b;
                // operands agree in sign but the sum does not
                v = (funct == 6'h20) && (a[31] == b[31]) && (r[31] != a[31]);
            end
            6'h22, 6'h23: begin
                r = a - b;
                v = (funct == 6'h22) && (a[31] != b[31]) && (r[31] != a[31]);
            end
            6'h26: r = a ^ b;
            6'h27: r = ~(a | b);
            6'h2a: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6'h2b: r = (a < b) ? 32'd1 : 32'd0;
            default: r = '0;
        endcase
        return {v, r};
    endfunction

    // reference 64-bit product built by shift and add
    function automatic logic [63:0] model_mul(input logic is_signed, input word_t a,
                                              input word_t b);
        logic [63:0] acc;
        logic [63:0] ma;
        logic [63:0] mb;
        acc = '0;
        ma  = is_signed ? {{32{a[31]}}, a} : {32'd0, a};
        mb  = is_signed ? {{32{b[31]}}, b} : {32'd0, b};
        for (int i = 0; i < 64; i++) begin
            if (mb[i]) begin
                acc = acc + (ma << i);
            end
        end
        return acc;
    endfunction

    task automatic add_vector(input string name, input instr_t instr, input word_t a,
                              input word_t b, input word_t exp_res, input logic ovf,
                              input logic rsvd);
        vector_t v;
        v.name       = name;
        v.instr      = instr;
        v.srca       = a;
        v.srcb       = b;
        v.pc         = next_pc;
        v.exp_result = exp_res;
        v.exp_ovf    = ovf;
        v.exp_rsvd   = rsvd;
        vectors.push_back(v);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic drive_vector(input vector_t v);
        i_valid = 1'b1;
        i_instr = v.instr;
        i_srca  = v.srca;
        i_srcb  = v.srcb;
        i_pc    = v.pc;
    endtask

    task automatic check_outputs(input vector_t v);
        compare_value({v.name, " valid"}, 32'd1, o_valid);
        compare_value({v.name, " result"}, v.exp_result, o_result);
        compare_value({v.name, " overflow"}, v.exp_ovf, o_overflow);
        compare_value({v.name, " rsvd"}, v.exp_rsvd, o_rsvd);
    endtask

    initial begin
        word_t       ra;
        word_t       rb;
        logic [32:0] model;
        logic [63:0] prod;

        i_rst_n = 1'b1;
        i_valid = 1'b0;
        i_instr = '0;
        i_srca  = '0;
        i_srcb  = '0;
        i_pc    = '0;

        // HI and LO come out of reset as zero
        add_vector("mfhi_reset", rtype(6'h10, 0), 'h0, 'h0, 'h0, 0, 0);
        add_vector("mflo_reset", rtype(6'h12, 0), 'h0, 'h0, 'h0, 0, 0);
        add_vector("add", rtype(6'h20, 0), 'd5, 'd7, 'd12, 0, 0);
        add_vector("add_ovf", rtype(6'h20, 0), 'h7fffffff, 'h1, 'h80000000, 1, 0);
        add_vector("addu_wrap", rtype(6'h21, 0), 'h7fffffff, 'h1, 'h80000000, 0, 0);
        add_vector("sub", rtype(6'h22, 0), 'd10, 'd3, 'd7, 0, 0);
        add_vector("sub_ovf", rtype(6'h22, 0), 'h80000000, 'h1, 'h7fffffff, 1, 0);
        add_vector("subu", rtype(6'h23, 0), 'h80000000, 'h1, 'h7fffffff, 0, 0);
        add_vector("addi_neg", itype(6'h08, 0, 'hfffc), 'd10, 'hdeadbeef, 'd6, 0, 0);
        add_vector("addi_ovf", itype(6'h08, 0, 'h0010), 'h7ffffff0, 'h0, 'h80000000, 1, 0);
        add_vector("addiu_wrap", itype(6'h09, 0, 'h0001), 'h7fffffff, 'h0, 'h80000000, 0, 0);
        add_vector("and", rtype(6'h24, 0), 'hf0f0ff00, 'h0ff0f0f0, 'h00f0f000, 0, 0);
        add_vector("or", rtype(6'h25, 0), 'hf0000f00, 'h0f0000f0, 'hff000ff0, 0, 0);
        add_vector("xor", rtype(6'h26, 0), 'hffff0000, 'h0f0f0f0f, 'hf0f00f0f, 0, 0);
        add_vector("nor", rtype(6'h27, 0), 'h0000ffff, 'h00ff0000, 'hff000000, 0, 0);
        add_vector("andi", itype(6'h0c, 0, 'h8001), 'hffffffff, 'hdeadbeef, 'h00008001, 0, 0);
        add_vector("ori", itype(6'h0d, 0, 'h8000), 'h12340000, 'h0, 'h12348000, 0, 0);
        add_vector("xori", itype(6'h0e, 0, 'hffff), 'hffffffff, 'h0, 'hffff0000, 0, 0);
        add_vector("lui", itype(6'h0f, 0, 'h8765), 'h11111111, 'h0, 'h87650000, 0, 0);
        add_vector("slt", rtype(6'h2a, 0), 'hffffffff, 'h1, 'h1, 0, 0);
        add_vector("sltu", rtype(6'h2b, 0), 'hffffffff, 'h1, 'h0, 0, 0);
        // 5 is not below -1 when the compare is signed
        add_vector("slti", itype(6'h0a, 0, 'hffff), 'd5, 'h0, 'h0, 0, 0);
        // only the sign-extended immediate lies above 0x10000
        add_vector("sltiu", itype(6'h0b, 0, 'hffff), 'h00010000, 'h0, 'h1, 0, 0);
        add_vector("sll_0", rtype(6'h00, 0), 'h0, 'h80000001, 'h80000001, 0, 0);
        add_vector("sll_31", rtype(6'h00, 31), 'h0, 'h00000003, 'h80000000, 0, 0);
        add_vector("srl_1", rtype(6'h02, 1), 'h0, 'h80000001, 'h40000000, 0, 0);
        add_vector("sra_1", rtype(6'h03, 1), 'h0, 'h80000000, 'hc0000000, 0, 0);
        add_vector("sra_31", rtype(6'h03, 31), 'h0, 'h80000000, 'hffffffff, 0, 0);
        // shamt field is ignored by the variable forms
        add_vector("sllv_1", rtype(6'h04, 9), 'hffffffe1, 'h1, 'h2, 0, 0);
        add_vector("srlv_31", rtype(6'h06, 0), 'h3f, 'h80000000, 'h1, 0, 0);
        add_vector("srav_0", rtype(6'h07, 0), 'h20, 'h80000001, 'h80000001, 0, 0);
        next_pc = 'h00400100;
        add_vector("jal", itype(6'h03, 0, 'h0000), 'h0, 'h0, 'h00400108, 0, 0);
        add_vector("jalr", rtype(6'h09, 0), 'h0, 'h0, 'h0040010c, 0, 0);
        add_vector("bltzal", itype(6'h01, 'h10, 'hfff0), 'h0, 'h0, 'h00400110, 0, 0);
        next_pc = 'hfffffffc;
        add_vector("bgezal_wrap", itype(6'h01, 'h11, 'h0004), 'h0, 'h0, 'h00000004, 0, 0);
        next_pc = 'h00400200;
        add_vector("mult", rtype(6'h18, 0), 'hfffffffe, 'd3, 'h0, 0, 0);
        add_vector("mfhi_mult", rtype(6'h10, 0), 'h0, 'h0, 'hffffffff, 0, 0);
        add_vector("mflo_mult", rtype(6'h12, 0), 'h0, 'h0, 'hfffffffa, 0, 0);
        add_vector("multu", rtype(6'h19, 0), 'hfffffffe, 'd3, 'h0, 0, 0);
        add_vector("mfhi_multu", rtype(6'h10, 0), 'h0, 'h0, 'h00000002, 0, 0);
        add_vector("mflo_multu", rtype(6'h12, 0), 'h0, 'h0, 'hfffffffa, 0, 0);
        add_vector("mthi", rtype(6'h11, 0), 'h13579bdf, 'h0, 'h0, 0, 0);
        add_vector("mtlo", rtype(6'h13, 0), 'h2468ace0, 'h0, 'h0, 0, 0);
        add_vector("rsvd_opcode", itype(6'h3f, 0, 'hffff), 'hffffffff, 'hffffffff, 'h0, 0, 1);
        add_vector("rsvd_funct", rtype(6'h1a, 0), 'h7, 'h7, 'h0, 0, 1);
        add_vector("mfhi_kept", rtype(6'h10, 0), 'h0, 'h0, 'h13579bdf, 0, 0);
        add_vector("mflo_kept", rtype(6'h12, 0), 'h0, 'h0, 'h2468ace0, 0, 0);

        for (int i = 0; i < 8; i++) begin
            rng_state = xorshift32(rng_state);
            ra = rng_state;
            rng_state = xorshift32(rng_state);
            rb = rng_state;
            model = model_alu(rand_funct[i], ra, rb);
            add_vector($sformatf("rand_%0d", i), rtype(rand_funct[i], 0), ra, rb,
                       model[31:0], model[32], 0);
        end
        rng_state = xorshift32(rng_state);
        ra = rng_state;
        rng_state = xorshift32(rng_state);
        rb = rng_state;
        prod = model_mul(1'b0, ra, rb);
        add_vector("rand_multu", rtype(6'h19, 0), ra, rb, 'h0, 0, 0);
        add_vector("rand_mfhi", rtype(6'h10, 0), 'h0, 'h0, prod[63:32], 0, 0);
        add_vector("rand_mflo", rtype(6'h12, 0), 'h0, 'h0, prod[31:0], 0, 0);
        rng_state = xorshift32(rng_state);
        ra = rng_state;
        rng_state = xorshift32(rng_state);
        rb = rng_state;
        prod = model_mul(1'b1, ra, rb);
        add_vector("rand_mult", rtype(6'h18, 0), ra, rb, 'h0, 0, 0);
        add_vector("rand_mfhi_s", rtype(6'h10, 0), 'h0, 'h0, prod[63:32], 0, 0);
        add_vector("rand_mflo_s", rtype(6'h12, 0), 'h0, 'h0, prod[31:0], 0, 0);

        cycle_limit = RESET_CYCLES + vectors.size() + 20;

        @(negedge i_clk);
        i_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_rst_n = 1'b1;

        // back to back, each result checked on the falling edge after its capture
        for (int k = 0; k <= vectors.size(); k++) begin
            @(negedge i_clk);
            if (k > 0) begin
                check_outputs(vectors[k - 1]);
            end
            if (k < vectors.size()) begin
                drive_vector(vectors[k]);
            end else begin
                i_valid = 1'b0;
            end
        end
        repeat (2) begin
            @(negedge i_clk);
            compare_value("idle valid", 32'd0, o_valid);
        end

        if (exec_stage_i.exec_stage_props_i.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("%0d assertion failures seen", exec_stage_i.exec_stage_props_i.fail_count);
            $display("Regression failed");
            $fatal(1, "stopped after assertion failures");
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/mips_exec_pkg.sv
verilog/exec_ctrl.sv
verilog/arith_unit.sv
verilog/logic_shift_unit.sv
verilog/hilo_unit.sv
verilog/result_select.sv
verilog/exec_stage.sv
testbench/exec_stage_props.sv
testbench/exec_stage_tb.sv

// File: Bender.yml
package:
  name: mips_exec_stage

sources:
  - files:
      - verilog/mips_exec_pkg.sv
      - verilog/exec_ctrl.sv
      - verilog/arith_unit.sv
      - verilog/logic_shift_unit.sv
      - verilog/hilo_unit.sv
      - verilog/result_select.sv
      - verilog/exec_stage.sv
  - target: test
    files:
      - testbench/exec_stage_props.sv
      - testbench/exec_stage_tb.sv
